/* src/vex_pkg.sv */
package vex_pkg;

  localparam int WORD_W = 32;
  localparam int LANES  = 2;
  localparam int VREG_W = 5;
  localparam int NF_W   = 3;

  typedef logic [WORD_W-1:0] word_t;

  typedef enum logic [2:0] {
    FU_ALU  = 3'd0,
    FU_RED  = 3'd1,
    FU_MASK = 3'd2,
    FU_LS   = 3'd3,
    FU_MOVE = 3'd4
  } fu_e;

  typedef enum logic [3:0] {
    VALU_ADD  = 4'd0,
    VALU_SUB  = 4'd1,
    VALU_AND  = 4'd2,
    VALU_OR   = 4'd3,
    VALU_XOR  = 4'd4,
    VALU_MIN  = 4'd5,
    VALU_MINU = 4'd6,
    VALU_MAX  = 4'd7,
    VALU_MAXU = 4'd8
  } valu_e;

  typedef enum logic [1:0] {SRC_V, SRC_I, SRC_X} src_e;

  // also used as the load/store element width
  typedef enum logic [1:0] {SEW8, SEW16, SEW32} sew_e;

  typedef enum logic [1:0] {MASK_SBF, MASK_SIF, MASK_SOF} mask_op_e;

  typedef enum logic [1:0] {STRIDE_UNIT, STRIDE_STRIDED, STRIDE_SEGMENT} stride_e;

  typedef enum logic [1:0] {MOVE_NONE, MOVE_V_V, MOVE_X_S} move_e;

  // decoded op from upstream, index 0 is lane 0
  typedef struct packed {
    logic                   valid;
    fu_e                    fu;
    valu_e                  aluop;
    mask_op_e               mask_op;
    move_e                  move;
    src_e                   rs1_src;
    src_e                   rs2_src;
    sew_e                   sew;
    word_t [LANES-1:0]      vs1;
    word_t [LANES-1:0]      vs2;
    word_t [LANES-1:0]      vs3;
    word_t                  xs1;
    word_t                  xs2;
    word_t                  imm;
    logic                   load;
    logic                   store;
    stride_e                stride;
    word_t                  stride_val;
    logic [NF_W-1:0]        nf;
    logic                   whole_reg;
    logic [LANES-1:0]       wen;
    logic [VREG_W-1:0]      vd;
    logic                   rd_wen;
    logic [VREG_W-1:0]      rd_sel;
  } dec_op_t;

  typedef struct packed {
    word_t op_a;
    word_t op_b;
  } lane_ops_t;

  // toward the memory stage; result0/1 hold addresses for loads and stores
  typedef struct packed {
    logic              valid;
    logic              load;
    logic              store;
    word_t             result0;
    word_t             result1;
    word_t             storedata0;
    word_t             storedata1;
    logic [LANES-1:0]  wen;
    logic [VREG_W-1:0] vd;
    logic              rd_wen;
    logic [VREG_W-1:0] rd_sel;
    word_t             rd_data;
  } mem_op_t;

endpackage

/* src/operand_decode.sv */
`timescale 1ns/1ps

module operand_decode
  import vex_pkg::*;
(
  input  dec_op_t   op,
  output lane_ops_t lane0_ops,
  output lane_ops_t lane1_ops
);

  // scalar and immediate sources are broadcast to every lane
  function automatic word_t pick_src(src_e sel, word_t vword, word_t imm, word_t xreg);
    word_t val;
    case (sel)
      SRC_V:   val = vword;
      SRC_I:   val = imm;
      SRC_X:   val = xreg;
      default: val = '0;
    endcase
    return val;
  endfunction

  // op_a follows rs1 (vs1 side)
  always_comb begin
    lane0_ops.op_a = pick_src(op.rs1_src, op.vs1[0], op.imm, op.xs1);
    lane1_ops.op_a = pick_src(op.rs1_src, op.vs1[1], op.imm, op.xs1);
  end

  // op_b follows rs2 (vs2 side)
  always_comb begin
    lane0_ops.op_b = pick_src(op.rs2_src, op.vs2[0], op.imm, op.xs2);
    lane1_ops.op_b = pick_src(op.rs2_src, op.vs2[1], op.imm, op.xs2);
  end

endmodule

/* src/vector_lane.sv */
`timescale 1ns/1ps

module vector_lane
  import vex_pkg::*;
(
  input  lane_ops_t ops,
  input  valu_e     aluop,
  input  sew_e      sew,
  output word_t     result
);

  word_t res8;
  word_t res16;
  word_t res32;

  // a and b arrive zero extended, w is the element width in bits
  // compares are b against a, so sub is b - a
  function automatic word_t elem_op(valu_e op, word_t a, word_t b, int unsigned w);
    logic signed [WORD_W-1:0] sa;
    logic signed [WORD_W-1:0] sb;
    logic lt_s;
    logic lt_u;
    sa = $signed(a << (WORD_W - w));
    sa = sa >>> (WORD_W - w);
    sb = $signed(b << (WORD_W - w));
    sb = sb >>> (WORD_W - w);
    lt_s = sb < sa;
    lt_u = b < a;
    case (op)
      VALU_ADD:  return a + b;
      VALU_SUB:  return b - a;
      VALU_AND:  return a & b;
      VALU_OR:   return a | b;
      VALU_XOR:  return a ^ b;
      VALU_MIN:  return lt_s ? b : a;
      VALU_MINU: return lt_u ? b : a;
      VALU_MAX:  return lt_s ? a : b;
      VALU_MAXU: return lt_u ? a : b;
      default:   return '0;
    endcase
  endfunction

  // every width computed in parallel, truncation drops inter-element carries
  always_comb begin
    word_t tmp;
    for (int i = 0; i < 4; i++) begin
      tmp = elem_op(aluop, {24'b0, ops.op_a[8*i +: 8]}, {24'b0, ops.op_b[8*i +: 8]}, 8);
      res8[8*i +: 8] = tmp[7:0];
    end
    for (int i = 0; i < 2; i++) begin
      tmp = elem_op(aluop, {16'b0, ops.op_a[16*i +: 16]}, {16'b0, ops.op_b[16*i +: 16]}, 16);
      res16[16*i +: 16] = tmp[15:0];
    end
    res32 = elem_op(aluop, ops.op_a, ops.op_b, WORD_W);
  end

  always_comb begin
    case (sew)
      SEW8:    result = res8;
      SEW16:   result = res16;
      default: result = res32;
    endcase
  end

  always_comb begin
    if (!$isunknown(sew)) begin
      assert (sew inside {SEW8, SEW16, SEW32})
        else $error("vector_lane: undefined sew encoding %0b", sew);
    end
  end

endmodule

/* src/reduction_combine.sv */
`timescale 1ns/1ps

module reduction_combine
  import vex_pkg::*;
(
  input  word_t lane0_res,
  input  word_t lane1_res,
  input  valu_e aluop,
  input  sew_e  sew,
  output word_t red_res
);

  logic lt_s;
  logic lt_u;

  // signed compare only looks at the low element
  always_comb begin
    lt_u = lane1_res < lane0_res;
    case (sew)
      SEW8:    lt_s = $signed(lane1_res[7:0]) < $signed(lane0_res[7:0]);
      SEW16:   lt_s = $signed(lane1_res[15:0]) < $signed(lane0_res[15:0]);
      default: lt_s = $signed(lane1_res) < $signed(lane0_res);
    endcase
  end

  always_comb begin
    case (aluop)
      VALU_ADD:  red_res = lane0_res + lane1_res;
      VALU_AND:  red_res = lane0_res & lane1_res;
      VALU_OR:   red_res = lane0_res | lane1_res;
      VALU_XOR:  red_res = lane0_res ^ lane1_res;
      VALU_MIN:  red_res = lt_s ? lane1_res : lane0_res;
      VALU_MINU: red_res = lt_u ? lane1_res : lane0_res;
      VALU_MAX:  red_res = lt_s ? lane0_res : lane1_res;
      VALU_MAXU: red_res = lt_u ? lane0_res : lane1_res;
      // sub has no reduction form
      default:   red_res = '0;
    endcase
  end

endmodule

/* src/mask_first_unit.sv */
`timescale 1ns/1ps

module mask_first_unit
  import vex_pkg::*;
(
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      flush,
  input  logic                      accept,
  input  fu_e                       fu,
  input  mask_op_e                  mask_op,
  input  logic [LANES*WORD_W-1:0]   src,
  output logic [LANES*WORD_W-1:0]   mask_res
);

  logic                    found;
  logic [LANES*WORD_W-1:0] first_bit;
  logic [LANES*WORD_W-1:0] below_first;

  // isolate lowest set bit
  assign first_bit = src & (~src + 1'b1);

  // with no set bit this wraps to all ones, which is what sbf/sif want
  assign below_first = first_bit - 1'b1;

  always_comb begin
    if (found) begin
      // first bit was in an earlier chunk
      mask_res = '0;
    end else begin
      case (mask_op)
        MASK_SBF: mask_res = below_first;
        MASK_SIF: mask_res = below_first | first_bit;
        MASK_SOF: mask_res = first_bit;
        default:  mask_res = '0;
      endcase
    end
  end

  // found spans consecutive mask chunks, any other op ends the sequence
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      found <= 1'b0;
    end else if (flush) begin
      found <= 1'b0;
    end else if (accept) begin
      if (fu != FU_MASK) begin
        found <= 1'b0;
      end else if (|src) begin
        found <= 1'b1;
      end
    end
  end

endmodule

/* src/ls_addr_gen.sv */
`timescale 1ns/1ps

module ls_addr_gen
  import vex_pkg::*;
(
  input  word_t           xs1,
  input  word_t           stride_val,
  input  stride_e         stride,
  input  logic [NF_W-1:0] nf,
  input  logic            whole_reg,
  input  sew_e            eew,
  output word_t           addr0,
  output word_t           addr1
);

  logic [1:0] size_shift;
  word_t      elem_bytes;
  word_t      field_off;
  word_t      step;

  // log2 of element size in bytes
  always_comb begin
    case (eew)
      SEW8:    size_shift = 2'd0;
      SEW16:   size_shift = 2'd1;
      default: size_shift = 2'd2;
    endcase
  end

  assign elem_bytes = word_t'(1) << size_shift;

  // segment field offset is nf elements in
  assign field_off = word_t'(nf) << size_shift;

  assign addr0 = whole_reg ? xs1 : xs1 + field_off;

  always_comb begin
    case (stride)
      STRIDE_UNIT:    step = elem_bytes;
      STRIDE_STRIDED: step = stride_val;
      // whole segment of nf+1 fields per element
      STRIDE_SEGMENT: step = (word_t'(nf) + 1'b1) << size_shift;
      default:        step = elem_bytes;
    endcase
  end

  assign addr1 = addr0 + step;

endmodule

/* src/result_latch.sv */
`timescale 1ns/1ps

module result_latch
  import vex_pkg::*;
(
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    stall,
  input  logic                    flush,
  input  dec_op_t                 op,
  input  word_t                   lane0_res,
  input  word_t                   lane1_res,
  input  word_t                   red_res,
  input  word_t                   addr0,
  input  word_t                   addr1,
  input  logic [LANES*WORD_W-1:0] mask_res,
  output logic                    accept,
  output mem_op_t                 out
);

  mem_op_t next_out;

  assign accept = op.valid && !stall && !flush;

  always_comb begin
    next_out            = '0;
    next_out.valid      = 1'b1;
    next_out.load       = op.load;
    next_out.store      = op.store;
    next_out.storedata0 = op.vs3[0];
    next_out.storedata1 = op.vs3[1];
    next_out.wen        = op.wen;
    next_out.vd         = op.vd;
    next_out.rd_wen     = op.rd_wen;
    next_out.rd_sel     = op.rd_sel;
    // scalar move takes element 0 of vs2
    if (op.fu == FU_MOVE && op.move == MOVE_X_S) begin
      next_out.rd_data = op.vs2[0];
    end
    case (op.fu)
      FU_ALU: begin
        next_out.result0 = lane0_res;
        next_out.result1 = lane1_res;
      end
      FU_RED: begin
        next_out.result0 = red_res;
        next_out.result1 = lane1_res;
      end
      FU_MASK: begin
        next_out.result0 = mask_res[WORD_W-1:0];
        next_out.result1 = mask_res[LANES*WORD_W-1:WORD_W];
      end
      FU_LS: begin
        next_out.result0 = addr0;
        next_out.result1 = addr1;
      end
      FU_MOVE: begin
        if (op.move == MOVE_V_V) begin
          next_out.result0 = op.vs1[0];
          next_out.result1 = op.vs1[1];
        end
      end
      default: ;
    endcase
  end

  // an idle cycle drops valid so a finished op is seen only once
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out <= '0;
    end else if (flush) begin
      out <= '0;
    end else if (!stall) begin
      if (accept) begin
        out <= next_out;
      end else begin
        out.valid <= 1'b0;
      end
    end
  end

  a_flush_kills_valid: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !out.valid)
    else $error("result_latch: out.valid high after flush");

  a_stall_holds_out: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !flush) |=> $stable(out))
    else $error("result_latch: out changed during stall");

endmodule

/* src/vector_execute_top.sv */
`timescale 1ns/1ps

module vector_execute_top
  import vex_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  dec_op_t op,
  input  logic    stall,
  input  logic    flush,
  output mem_op_t out
);

  lane_ops_t               lane0_ops;
  lane_ops_t               lane1_ops;
  word_t                   lane0_res;
  word_t                   lane1_res;
  word_t                   red_res;
  word_t                   addr0;
  word_t                   addr1;
  logic [LANES*WORD_W-1:0] mask_res;
  logic                    accept;

  operand_decode i_operand_decode (
    .op        (op),
    .lane0_ops (lane0_ops),
    .lane1_ops (lane1_ops)
  );

  vector_lane i_lane0 (
    .ops    (lane0_ops),
    .aluop  (op.aluop),
    .sew    (op.sew),
    .result (lane0_res)
  );

  vector_lane i_lane1 (
    .ops    (lane1_ops),
    .aluop  (op.aluop),
    .sew    (op.sew),
    .result (lane1_res)
  );

  reduction_combine i_reduction_combine (
    .lane0_res (lane0_res),
    .lane1_res (lane1_res),
    .aluop     (op.aluop),
    .sew       (op.sew),
    .red_res   (red_res)
  );

  // mask source is the raw vs2 group, lane 1 on top
  mask_first_unit i_mask_first_unit (
    .CLK      (CLK),
    .nRST     (nRST),
    .flush    (flush),
    .accept   (accept),
    .fu       (op.fu),
    .mask_op  (op.mask_op),
    .src      ({op.vs2[1], op.vs2[0]}),
    .mask_res (mask_res)
  );

  // load/store width shares the sew field
  ls_addr_gen i_ls_addr_gen (
    .xs1        (op.xs1),
    .stride_val (op.stride_val),
    .stride     (op.stride),
    .nf         (op.nf),
    .whole_reg  (op.whole_reg),
    .eew        (op.sew),
    .addr0      (addr0),
    .addr1      (addr1)
  );

  result_latch i_result_latch (
    .CLK       (CLK),
    .nRST      (nRST),
    .stall     (stall),
    .flush     (flush),
    .op        (op),
    .lane0_res (lane0_res),
    .lane1_res (lane1_res),
    .red_res   (red_res),
    .addr0     (addr0),
    .addr1     (addr1),
    .mask_res  (mask_res),
    .accept    (accept),
    .out       (out)
  );

endmodule

/* dv/tb_vector_execute.sv */
`timescale 1ns/1ps

module tb_vector_execute
  import vex_pkg::*;
();

  localparam int ALU_OPS     = 9 * 3 * 3 + 2;
  localparam int RED_OPS     = 9 * 3;
  localparam int MASK_OPS    = 3 * 6 + 3;
  localparam int LS_OPS      = 3 * 3 * 8 * 2;
  localparam int FLOW_CYCLES = 20;
  // each issued op takes two cycles plus reset and slack
  localparam int LIMIT_CYCLES = 2 * (ALU_OPS + RED_OPS + MASK_OPS + LS_OPS) + FLOW_CYCLES + 100;

  logic    CLK;
  logic    nRST;
  logic    stall;
  logic    flush;
  dec_op_t op;
  mem_op_t out;

  int unsigned errors;
  int unsigned checks;
  logic [31:0] lfsr;
  // model copy of the mask found state
  logic        found_ref;

  vector_execute_top i_dut (
    .CLK   (CLK),
    .nRST  (nRST),
    .op    (op),
    .stall (stall),
    .flush (flush),
    .out   (out)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic word_t take_bits(int unsigned nbits);
    word_t val;
    logic  fb;
    val = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // never zero so a first set bit always exists
  function automatic logic [63:0] rand_chunk();
    return ({take_bits(32), take_bits(32)} << take_bits(5)) | (64'd1 << 63);
  endfunction

  function automatic longint sext(longint unsigned v, int w);
    longint unsigned m;
    m = (64'd1 << w) - 64'd1;
    v = v & m;
    return v[w-1] ? longint'(v) - longint'(m) - 1 : longint'(v);
  endfunction

  // one element with b compared against a
  function automatic word_t elem_ref(valu_e f, longint unsigned a, longint unsigned b, int w);
    longint unsigned r;
    longint          sa;
    longint          sb;
    sa = sext(a, w);
    sb = sext(b, w);
    case (f)
      VALU_ADD:  r = a + b;
      VALU_SUB:  r = b - a;
      VALU_AND:  r = a & b;
      VALU_OR:   r = a | b;
      VALU_XOR:  r = a ^ b;
      VALU_MIN:  r = (sb < sa) ? b : a;
      VALU_MINU: r = (b < a) ? b : a;
      VALU_MAX:  r = (sb > sa) ? b : a;
      VALU_MAXU: r = (b > a) ? b : a;
      default:   r = 0;
    endcase
    return word_t'(r & ((64'd1 << w) - 64'd1));
  endfunction

  function automatic word_t lane_ref(valu_e f, sew_e s, word_t a, word_t b);
    word_t r;
    word_t m;
    int    w;
    w = 8 << int'(s);
    m = word_t'((64'd1 << w) - 64'd1);
    r = '0;
    for (int k = 0; k < 32 / w; k++) begin
      r = r | (elem_ref(f, (a >> (k * w)) & m, (b >> (k * w)) & m, w) << (k * w));
    end
    return r;
  endfunction

  function automatic word_t red_ref(valu_e f, sew_e s, word_t l0, word_t l1);
    longint s0;
    longint s1;
    s0 = sext(l0, 8 << int'(s));
    s1 = sext(l1, 8 << int'(s));
    case (f)
      VALU_ADD:  return l0 + l1;
      VALU_AND:  return l0 & l1;
      VALU_OR:   return l0 | l1;
      VALU_XOR:  return l0 ^ l1;
      // lane 1 against lane 0 and signed on the low element only
      VALU_MIN:  return (s1 < s0) ? l1 : l0;
      VALU_MAX:  return (s1 < s0) ? l0 : l1;
      VALU_MINU: return (l1 < l0) ? l1 : l0;
      VALU_MAXU: return (l1 < l0) ? l0 : l1;
      default:   return '0;
    endcase
  endfunction

  function automatic logic [63:0] mask_ref(mask_op_e m, logic [63:0] src, logic found);
    logic [63:0] r;
    int          first;
    r     = '0;
    first = 64;
    for (int i = 63; i >= 0; i--) begin
      if (src[i]) first = i;
    end
    if (found) return r;
    for (int i = 0; i < 64; i++) begin
      case (m)
        MASK_SBF: r[i] = (i < first);
        MASK_SIF: r[i] = (i <= first);
        MASK_SOF: r[i] = (i == first);
        default:  r[i] = 1'b0;
      endcase
    end
    return r;
  endfunction

  task automatic check_word(string what, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic dec_op_t random_op();
    dec_op_t o;
    o            = '0;
    o.vs1[0]     = take_bits(32);
    o.vs1[1]     = take_bits(32);
    o.vs2[0]     = take_bits(32);
    o.vs2[1]     = take_bits(32);
    o.vs3[0]     = take_bits(32);
    o.vs3[1]     = take_bits(32);
    o.xs1        = take_bits(32);
    o.xs2        = take_bits(32);
    o.imm        = take_bits(32);
    o.stride_val = take_bits(32);
    o.wen        = 2'(take_bits(2));
    o.vd         = VREG_W'(take_bits(VREG_W));
    o.rd_sel     = VREG_W'(take_bits(VREG_W));
    return o;
  endfunction

  // drive on the falling edge and return one falling edge after acceptance
  task automatic issue(input dec_op_t o);
    @(negedge CLK);
    op       = o;
    op.valid = 1'b1;
    @(negedge CLK);
    op = '0;
    if (o.fu != FU_MASK) found_ref = 1'b0;
  endtask

  task automatic test_alu();
    dec_op_t o;
    word_t   a;
    word_t   b;
    for (int f = 0; f < 9; f++) begin
      for (int s = 0; s < 3; s++) begin
        for (int k = 0; k < 3; k++) begin
          o         = random_op();
          o.fu      = FU_ALU;
          o.aluop   = valu_e'(f);
          o.sew     = sew_e'(s);
          o.rs1_src = src_e'(k);
          o.rs2_src = src_e'((k + 1) % 3);
          issue(o);
          for (int l = 0; l < 2; l++) begin
            a = (o.rs1_src == SRC_V) ? o.vs1[l] : (o.rs1_src == SRC_I) ? o.imm : o.xs1;
            b = (o.rs2_src == SRC_V) ? o.vs2[l] : (o.rs2_src == SRC_I) ? o.imm : o.xs2;
            check_word($sformatf("alu %s sew%0d src%0d lane%0d", o.aluop.name(), 8 << s, k, l),
                       (l == 0) ? out.result0 : out.result1, lane_ref(o.aluop, o.sew, a, b));
          end
          check_word("alu ctrl", {out.valid, out.wen, out.vd}, {1'b1, o.wen, o.vd});
        end
      end
    end
    o      = random_op();
    o.fu   = FU_MOVE;
    o.move = MOVE_V_V;
    issue(o);
    check_word("vector move", {out.result1, out.result0}, {o.vs1[1], o.vs1[0]});
    o        = random_op();
    o.fu     = FU_MOVE;
    o.move   = MOVE_X_S;
    o.rd_wen = 1'b1;
    issue(o);
    check_word("scalar move data", out.rd_data, o.vs2[0]);
    check_word("scalar move rd", {out.rd_wen, out.rd_sel}, {1'b1, o.rd_sel});
  endtask

  task automatic test_reduction();
    dec_op_t o;
    word_t   l0;
    word_t   l1;
    for (int f = 0; f < 9; f++) begin
      for (int s = 0; s < 3; s++) begin
        o       = random_op();
        o.fu    = FU_RED;
        o.aluop = valu_e'(f);
        o.sew   = sew_e'(s);
        l0      = lane_ref(o.aluop, o.sew, o.vs1[0], o.vs2[0]);
        l1      = lane_ref(o.aluop, o.sew, o.vs1[1], o.vs2[1]);
        issue(o);
        check_word($sformatf("red %s sew%0d", o.aluop.name(), 8 << s), out.result0,
                   red_ref(o.aluop, o.sew, l0, l1));
        check_word("red lane1", out.result1, l1);
      end
    end
  endtask

  task automatic mask_step(mask_op_e m, logic [63:0] src);
    dec_op_t     o;
    logic [63:0] exp;
    o         = random_op();
    o.fu      = FU_MASK;
    o.mask_op = m;
    o.vs2[0]  = src[31:0];
    o.vs2[1]  = src[63:32];
    exp       = mask_ref(m, src, found_ref);
    issue(o);
    check_word($sformatf("mask %s src %h", m.name(), src), {out.result1, out.result0}, exp);
    found_ref = found_ref | (|src);
  endtask

  task automatic test_mask();
    dec_op_t o;
    for (int m = 0; m < 3; m++) begin
      // any non-mask op ends the previous sequence
      o = random_op();
      issue(o);
      mask_step(mask_op_e'(m), rand_chunk());
      mask_step(mask_op_e'(m), rand_chunk());
      o = random_op();
      issue(o);
      mask_step(mask_op_e'(m), 64'd0);
      mask_step(mask_op_e'(m), rand_chunk());
    end
  endtask

  task automatic test_ls();
    dec_op_t o;
    word_t   size;
    word_t   a0;
    word_t   step;
    for (int md = 0; md < 3; md++) begin
      for (int e = 0; e < 3; e++) begin
        for (int nf = 0; nf < 8; nf++) begin
          for (int wr = 0; wr < 2; wr++) begin
            o           = random_op();
            o.fu        = FU_LS;
            o.stride    = stride_e'(md);
            o.sew       = sew_e'(e);
            o.nf        = NF_W'(nf);
            o.whole_reg = wr[0];
            o.load      = wr[0];
            o.store     = !wr[0];
            size        = word_t'(1) << e;
            a0          = wr[0] ? o.xs1 : o.xs1 + word_t'(nf) * size;
            if (md == 0) step = size;
            else if (md == 1) step = o.stride_val;
            else step = word_t'(nf + 1) * size;
            issue(o);
            check_word($sformatf("ls mode%0d eew%0d nf%0d whole%0d", md, 8 << e, nf, wr),
                       {out.result1, out.result0}, {a0 + step, a0});
            check_word("ls load/store", {out.load, out.store}, {o.load, o.store});
            check_word("ls storedata", {out.storedata1, out.storedata0}, {o.vs3[1], o.vs3[0]});
          end
        end
      end
    end
  endtask

  task automatic test_flow();
    dec_op_t a;
    dec_op_t b;
    mem_op_t held;
    a      = random_op();
    a.fu   = FU_MOVE;
    a.move = MOVE_V_V;
    b      = a;
    b.vs1  = {take_bits(32), take_bits(32)};
    // expected out for op a, kept through the stall
    held            = '0;
    held.valid      = 1'b1;
    held.result0    = a.vs1[0];
    held.result1    = a.vs1[1];
    held.storedata0 = a.vs3[0];
    held.storedata1 = a.vs3[1];
    held.wen        = a.wen;
    held.vd         = a.vd;
    held.rd_sel     = a.rd_sel;
    issue(a);
    op       = b;
    op.valid = 1'b1;
    stall    = 1'b1;
    repeat (3) begin
      @(negedge CLK);
      checks++;
      if (out !== held) begin
        errors++;
        $display("CHECK FAILED at %0t: out changed while stalled", $time);
      end
    end
    stall = 1'b0;
    @(negedge CLK);
    op = '0;
    check_word("released op", {out.result1, out.result0}, {b.vs1[1], b.vs1[0]});
    check_word("released op valid", out.valid, 1);
    @(negedge CLK);
    check_word("released op seen once", out.valid, 0);
    // found set and then a flush over a stall with a valid mask op waiting
    mask_step(MASK_SOF, rand_chunk());
    op         = random_op();
    op.valid   = 1'b1;
    op.fu      = FU_MASK;
    op.mask_op = MASK_SOF;
    flush      = 1'b1;
    stall      = 1'b1;
    @(negedge CLK);
    flush     = 1'b0;
    stall     = 1'b0;
    op        = '0;
    found_ref = 1'b0;
    check_word("flush valid", out.valid, 0);
    checks++;
    if (out !== '0) begin
      errors++;
      $display("CHECK FAILED at %0t: out not cleared by flush", $time);
    end
    mask_step(MASK_SOF, rand_chunk());
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    lfsr      = 32'hdefa_7849;
    found_ref = 1'b0;
    nRST      = 1'b0;
    stall     = 1'b0;
    flush     = 1'b0;
    op        = '0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    check_word("reset state", {out.valid, out.load, out.store, out.wen, out.rd_wen}, '0);
    test_alu();
    test_reduction();
    test_mask();
    test_ls();
    test_flow();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge CLK);
    $display("timeout after %0d cycles, checks: %0d, errors: %0d", LIMIT_CYCLES, checks, errors);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* vector_execute_top.f */
src/vex_pkg.sv
src/operand_decode.sv
src/vector_lane.sv
src/reduction_combine.sv
src/mask_first_unit.sv
src/ls_addr_gen.sv
src/result_latch.sv
src/vector_execute_top.sv
dv/tb_vector_execute.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vector_execute
RTL_TOP   ?= vector_execute_top
FILELIST  ?= vector_execute_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
